//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef logic [31:0] instr32_t;
    typedef logic [15:0] instr16_t;
    typedef logic [6:0]  opcode_t;

    // Major opcodes of the base integer ISA
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_OPIMM  = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;

    // Low two bits of a compressed instruction, 2'b11 marks a full width one
    localparam logic [1:0] C_Q0 = 2'b00;
    localparam logic [1:0] C_Q1 = 2'b01;
    localparam logic [1:0] C_Q2 = 2'b10;

    // Compressed funct3 in bits 15:13
    localparam logic [2:0] C_F3_ADDI      = 3'b000;
    localparam logic [2:0] C_F3_JAL       = 3'b001;
    localparam logic [2:0] C_F3_LI        = 3'b010;
    localparam logic [2:0] C_F3_JR_MV_ADD = 3'b100;
    localparam logic [2:0] C_F3_J         = 3'b101;
    localparam logic [2:0] C_F3_BEQZ      = 3'b110;
    localparam logic [2:0] C_F3_BNEZ      = 3'b111;

endpackage

//--- hw/fetch_pkg.sv
package fetch_pkg;

    // Byte address
    typedef logic [31:0] addr_t;

    // Word address, the byte address without its two low bits
    typedef logic [29:0] waddr_t;

    typedef logic [31:0] word_t;

    // Read only APB3 request from the fetch master
    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        addr_t paddr;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
    } apb_rsp_t;

    // One realigned instruction toward decode
    typedef struct packed {
        addr_t                pc;
        rv_isa_pkg::instr32_t raw;
        rv_isa_pkg::instr32_t expanded;
        logic                 is_comp;
        logic                 is_ctrl;
        logic                 is_expandable;
    } fetch_out_t;

endpackage

//--- hw/fetch_apb_master.sv
`timescale 1ns/10ps

module fetch_apb_master
#(
    parameter logic [31:0] RESET_PC = 32'h0
)
(
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  logic                i_not_full,
    output fetch_pkg::apb_req_t o_apb_req,
    input  fetch_pkg::apb_rsp_t i_apb_rsp,
    output logic                o_push,
    output fetch_pkg::word_t    o_push_data
);

    import fetch_pkg::*;

    typedef enum logic [1:0] {IDLE, SETUP, ACCESS} state_t;

    state_t state;
    state_t state_next;
    waddr_t waddr;
    logic   done;

    assign done = (state == ACCESS) && i_apb_rsp.pready;

    // i_not_full already counts a push in the same cycle, so transfers can run back to back
    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
            begin
                if (i_not_full)
                    state_next = SETUP;
            end
            SETUP:
                state_next = ACCESS;
            ACCESS:
            begin
                if (i_apb_rsp.pready)
                    state_next = i_not_full ? SETUP : IDLE;
            end
            default:
                state_next = IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state <= IDLE;
            waddr <= RESET_PC[31:2];
        end
        else
        begin
            state <= state_next;
            if (done)
                waddr <= waddr + 30'd1;
        end
    end

    always_comb
    begin
        o_apb_req.psel    = state != IDLE;
        o_apb_req.penable = state == ACCESS;
        o_apb_req.pwrite  = 1'b0;
        o_apb_req.paddr   = {waddr, 2'b00};
    end

    assign o_push      = done;
    assign o_push_data = i_apb_rsp.prdata;

    a_penable_after_setup: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_apb_req.penable |-> o_apb_req.psel && $past(o_apb_req.psel));

    // Address holds from setup until the memory answers
    a_paddr_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_apb_req.psel && !(o_apb_req.penable && i_apb_rsp.pready)
        |=> $stable(o_apb_req.paddr));

endmodule

//--- hw/rv_fetch_buf.sv
`timescale 1ns/10ps

module rv_fetch_buf
#(
    parameter int          IADDR_BITS = 16,
    parameter int          DEPTH_BITS = 2,
    parameter logic [31:0] RESET_PC   = 32'h0
)
(
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    input  logic                  i_stall,
    input  logic                  i_push,
    input  fetch_pkg::word_t      i_data,
    output rv_isa_pkg::instr32_t  o_data,
    output logic [IADDR_BITS-2:0] o_pc,
    output logic                  o_not_empty,
    output logic                  o_not_full
);

    import rv_isa_pkg::*;
    import fetch_pkg::*;

    localparam int QSIZE = 2 ** DEPTH_BITS;

    word_t                 data  [QSIZE];
    word_t                 above [QSIZE];
    logic [QSIZE:0]        is_head;
    logic [IADDR_BITS-2:0] pc;
    logic [IADDR_BITS-2:0] pc_next;
    instr16_t              latch_hi;
    logic                  hi_valid;
    instr16_t              data_lo;
    instr16_t              data_hi;
    logic                  have_word;
    logic                  odd;
    logic                  is_comp;
    logic                  skip;
    logic                  consume;
    logic                  pop;

    // One-hot fill level, is_head[k] means k words are queued
    assign have_word = !is_head[0];
    assign odd       = pc[0];

    // At an odd halfword the low half is the upper half of the last popped word
    assign data_lo = odd ? latch_hi : data[0][15:0];
    assign data_hi = odd ? data[0][15:0] : data[0][31:16];
    assign is_comp = data_lo[1:0] != 2'b11;

    // Starting at an odd halfword with nothing latched, the first low half is dropped
    assign skip = odd && !hi_valid && have_word;

    always_comb
    begin
        if (!odd)
            o_not_empty = have_word;
        else
            o_not_empty = hi_valid && (is_comp || have_word);
    end

    assign consume = o_not_empty && !i_stall;
    assign pop     = (consume && (!odd || !is_comp)) || skip;
    assign pc_next = pc + (is_comp ? (IADDR_BITS-1)'(1) : (IADDR_BITS-1)'(2));

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            is_head  <= (QSIZE+1)'(1);
            pc       <= RESET_PC[IADDR_BITS-1:1];
            hi_valid <= 1'b0;
        end
        else
        begin
            if (i_push && !pop)
                is_head <= is_head << 1;
            else if (pop && !i_push)
                is_head <= is_head >> 1;
            if (consume)
                pc <= pc_next;
            // The latch holds a pending half exactly when the next pc is odd
            if (consume || skip)
                hi_valid <= skip || pc_next[0];
        end
    end

    always_comb
    begin
        for (int i = 0; i < QSIZE-1; i++)
            above[i] = data[i+1];
        above[QSIZE-1] = i_data;
    end

    always_ff @(posedge i_clk)
    begin
        if (pop)
            latch_hi <= data[0][31:16];
        for (int i = 0; i < QSIZE; i++)
        begin
            if (pop)
                data[i] <= (i_push && is_head[i+1]) ? i_data : above[i];
            else if (i_push && is_head[i])
                data[i] <= i_data;
        end
    end

    assign o_data     = {data_hi, data_lo};
    assign o_pc       = pc;
    assign o_not_full = !is_head[QSIZE] && !(is_head[QSIZE-1] && i_push && !pop);

    a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_push |-> !is_head[QSIZE]);

endmodule

//--- hw/rvc_expand.sv
`timescale 1ns/10ps

module rvc_expand
(
    input  rv_isa_pkg::instr32_t i_instr,
    output rv_isa_pkg::instr32_t o_expanded,
    output logic                 o_valid
);

    import rv_isa_pkg::*;

    instr16_t    c;
    logic [1:0]  quad;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [11:0] imm;

    assign c      = i_instr[15:0];
    assign quad   = c[1:0];
    assign funct3 = c[15:13];
    assign rd     = c[11:7];
    assign rs2    = c[6:2];

    // CI immediate, sign bit in c[12]
    assign imm = {{7{c[12]}}, c[6:2]};

    always_comb
    begin
        o_valid    = 1'b1;
        o_expanded = i_instr;
        if (quad == C_Q1 && funct3 == C_F3_LI)
        begin
            o_expanded = {imm, 5'd0, 3'b000, rd, OPC_OPIMM};
        end
        else if (quad == C_Q1 && funct3 == C_F3_ADDI)
        begin
            o_expanded = {imm, rd, 3'b000, rd, OPC_OPIMM};
        end
        else if (quad == C_Q2 && funct3 == C_F3_JR_MV_ADD && rs2 != 5'd0)
        begin
            // Bit 12 set is C.ADD, clear is C.MV
            if (c[12])
                o_expanded = {7'd0, rs2, rd, 3'b000, rd, OPC_OP};
            else
                o_expanded = {7'd0, rs2, 5'd0, 3'b000, rd, OPC_OP};
        end
        else
        begin
            o_valid = 1'b0;
        end
    end

endmodule

//--- hw/rv_predecode.sv
`timescale 1ns/10ps

module rv_predecode
(
    input  rv_isa_pkg::instr32_t i_instr,
    output logic                 o_is_comp,
    output logic                 o_is_ctrl
);

    import rv_isa_pkg::*;

    opcode_t    opcode;
    logic [1:0] quad;
    logic [2:0] funct3;
    logic       c_ctrl;
    logic       w_ctrl;

    assign opcode = i_instr[6:0];
    assign quad   = i_instr[1:0];
    assign funct3 = i_instr[15:13];

    assign o_is_comp = quad inside {C_Q0, C_Q1, C_Q2};

    // C.JR and C.JALR share funct3 with C.MV and C.ADD but have rs2 zero
    always_comb
    begin
        c_ctrl = 1'b0;
        if (quad == C_Q1)
            c_ctrl = funct3 inside {C_F3_J, C_F3_JAL, C_F3_BEQZ, C_F3_BNEZ};
        else if (quad == C_Q2 && funct3 == C_F3_JR_MV_ADD)
            c_ctrl = i_instr[6:2] == 5'd0;
    end

    assign w_ctrl    = opcode inside {OPC_JAL, OPC_JALR, OPC_BRANCH};
    assign o_is_ctrl = o_is_comp ? c_ctrl : w_ctrl;

endmodule

//--- hw/fetch_out_stage.sv
`timescale 1ns/10ps

module fetch_out_stage
#(
    parameter int IADDR_BITS = 16
)
(
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    input  logic                  i_avail,
    input  logic [IADDR_BITS-2:0] i_pc,
    input  rv_isa_pkg::instr32_t  i_raw,
    input  rv_isa_pkg::instr32_t  i_expanded,
    input  logic                  i_expandable,
    input  logic                  i_is_comp,
    input  logic                  i_is_ctrl,
    output logic                  o_take,
    input  logic                  i_out_ready,
    output logic                  o_out_valid,
    output fetch_pkg::fetch_out_t o_out
);

    import rv_isa_pkg::*;
    import fetch_pkg::*;

    instr32_t   raw;
    fetch_out_t out_d;

    // The upper half past a compressed instruction belongs to the next one
    assign raw = i_is_comp ? {16'h0, i_raw[15:0]} : i_raw;

    always_comb
    begin
        out_d.pc            = {{(32-IADDR_BITS){1'b0}}, i_pc, 1'b0};
        out_d.raw           = raw;
        out_d.expanded      = i_expandable ? i_expanded : raw;
        out_d.is_comp       = i_is_comp;
        out_d.is_ctrl       = i_is_ctrl;
        out_d.is_expandable = i_expandable;
    end

    assign o_take = i_avail && (!o_out_valid || i_out_ready);

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            o_out_valid <= 1'b0;
        else if (o_take)
            o_out_valid <= 1'b1;
        else if (i_out_ready)
            o_out_valid <= 1'b0;
    end

    always_ff @(posedge i_clk)
    begin
        if (o_take)
            o_out <= out_d;
    end

    a_hold_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out));

endmodule

//--- hw/rv_fetch_top.sv
`timescale 1ns/10ps

module rv_fetch_top
#(
    parameter int          IADDR_BITS = 16,
    parameter int          DEPTH_BITS = 2,
    parameter logic [31:0] RESET_PC   = 32'h0
)
(
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    output fetch_pkg::apb_req_t   o_apb_req,
    input  fetch_pkg::apb_rsp_t   i_apb_rsp,
    output logic                  o_out_valid,
    output fetch_pkg::fetch_out_t o_out,
    input  logic                  i_out_ready
);

    import rv_isa_pkg::*;
    import fetch_pkg::*;

    logic                  push;
    word_t                 push_data;
    logic                  not_full;
    logic                  not_empty;
    instr32_t              buf_data;
    logic [IADDR_BITS-2:0] buf_pc;
    logic                  take;
    instr32_t              expanded;
    logic                  expandable;
    logic                  is_comp;
    logic                  is_ctrl;

    fetch_apb_master
    #(
        .RESET_PC    (RESET_PC)
    )
    u_master
    (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_not_full  (not_full),
        .o_apb_req   (o_apb_req),
        .i_apb_rsp   (i_apb_rsp),
        .o_push      (push),
        .o_push_data (push_data)
    );

    rv_fetch_buf
    #(
        .IADDR_BITS  (IADDR_BITS),
        .DEPTH_BITS  (DEPTH_BITS),
        .RESET_PC    (RESET_PC)
    )
    u_buf
    (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_stall     (~take),
        .i_push      (push),
        .i_data      (push_data),
        .o_data      (buf_data),
        .o_pc        (buf_pc),
        .o_not_empty (not_empty),
        .o_not_full  (not_full)
    );

    rvc_expand u_expand
    (
        .i_instr    (buf_data),
        .o_expanded (expanded),
        .o_valid    (expandable)
    );

    rv_predecode u_predecode
    (
        .i_instr   (buf_data),
        .o_is_comp (is_comp),
        .o_is_ctrl (is_ctrl)
    );

    fetch_out_stage
    #(
        .IADDR_BITS   (IADDR_BITS)
    )
    u_out
    (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_avail      (not_empty),
        .i_pc         (buf_pc),
        .i_raw        (buf_data),
        .i_expanded   (expanded),
        .i_expandable (expandable),
        .i_is_comp    (is_comp),
        .i_is_ctrl    (is_ctrl),
        .o_take       (take),
        .i_out_ready  (i_out_ready),
        .o_out_valid  (o_out_valid),
        .o_out        (o_out)
    );

endmodule

//--- tb/tb_apb_imem.sv
`timescale 1ns/10ps

module tb_apb_imem
#(
    parameter int WORD_BITS = 10
)
(
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  fetch_pkg::apb_req_t i_apb_req,
    output fetch_pkg::apb_rsp_t o_apb_rsp
);

    import fetch_pkg::*;

    localparam int MEM_WORDS = 2 ** WORD_BITS;

    // Loaded by the testbench before reset is released
    word_t                mem [MEM_WORDS];
    apb_rsp_t             rsp_q = '0;
    int unsigned          wait_left;
    logic [WORD_BITS-1:0] idx;

    assign idx       = i_apb_req.paddr[WORD_BITS+1:2];
    assign o_apb_rsp = rsp_q;

    always @(posedge i_clk or negedge i_arst_n)
    begin : respond
        int unsigned draw;
        if (!i_arst_n)
        begin
            rsp_q.pready <= 1'b0;
            wait_left    <= 0;
        end
        else if (i_apb_req.psel && !i_apb_req.penable)
        begin
            // Setup cycle, so pick the wait states of the access that follows
            draw = $urandom_range(3, 0);
            wait_left <= draw;
            if (draw == 0)
            begin
                rsp_q.pready <= 1'b1;
                rsp_q.prdata <= mem[idx];
            end
        end
        else if (i_apb_req.penable && !rsp_q.pready)
        begin
            if (wait_left == 1)
            begin
                rsp_q.pready <= 1'b1;
                rsp_q.prdata <= mem[idx];
            end
            wait_left <= wait_left - 1;
        end
        else
        begin
            rsp_q.pready <= 1'b0;
        end
    end

endmodule

//--- tb/tb_fetch_top.sv
`timescale 1ns/10ps

module tb_fetch_top;

    import rv_isa_pkg::*;
    import fetch_pkg::*;

    localparam int          IADDR_BITS = 16;
    localparam int          DEPTH_BITS = 2;
    localparam logic [31:0] RESET_PC   = 32'h0000_0100;
    localparam int          MEM_BITS   = 10;
    localparam int          N_INSTR    = 200;
    // Up to 6 cycles per instruction with five times that as margin
    localparam int          MAX_CYCLES = N_INSTR * 30;

    logic        clk          = 1'b0;
    logic        arst_n       = 1'b0;
    logic        out_ready    = 1'b0;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        out_valid;
    fetch_out_t  dut_out;
    logic        fire;
    fetch_out_t  exp_tab [N_INSTR];
    fetch_out_t  exp_rec;
    int          out_count;
    int          cycles       = 0;
    int          cross_count  = 0;
    int          hold_left    = 0;
    logic        stall_seen;
    logic        backoff_seen;
    logic [31:0] exp_paddr;

    always #10 clk = ~clk;

    rv_fetch_top
    #(
        .IADDR_BITS  (IADDR_BITS),
        .DEPTH_BITS  (DEPTH_BITS),
        .RESET_PC    (RESET_PC)
    )
    u_dut
    (
        .i_clk       (clk),
        .i_arst_n    (arst_n),
        .o_apb_req   (apb_req),
        .i_apb_rsp   (apb_rsp),
        .o_out_valid (out_valid),
        .o_out       (dut_out),
        .i_out_ready (out_ready)
    );

    tb_apb_imem #(.WORD_BITS(MEM_BITS)) u_imem
    (
        .i_clk     (clk),
        .i_arst_n  (arst_n),
        .i_apb_req (apb_req),
        .o_apb_rsp (apb_rsp)
    );

    task automatic fail_with(input string what);
        $display("%s (at %0t ns)", what, $time);
        $display("STATUS: FAIL");
        $fatal(1, "stopping the run");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("error at %0t ns: %s expected %08h actual %08h", $time, name, expected, actual);
        $display("STATUS: FAIL");
        $fatal(1, "stopping the run");
    endtask

    task automatic write_half(input int hw, input instr16_t half);
        logic [31:0] baddr;
        baddr = RESET_PC + 32'(2 * hw);
        if (baddr[1])
            u_imem.mem[baddr[MEM_BITS+1:2]][31:16] = half;
        else
            u_imem.mem[baddr[MEM_BITS+1:2]][15:0] = half;
    endtask

    // Lays the program out halfword by halfword and records what decode must see
    task automatic build_program();
        int          hw_idx;
        int          cls;
        logic [31:0] rnd;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [5:0]  imm6;
        instr16_t    c;
        instr32_t    w;
        instr32_t    expw;
        logic        comp;
        logic        ctrl;
        logic        expd;
        hw_idx = 0;
        for (int i = 0; i < 2 ** MEM_BITS; i++)
            u_imem.mem[i] = {~i[15:0], i[15:0]};
        for (int n = 0; n < N_INSTR; n++)
        begin
            cls  = int'($urandom_range(10, 0));
            rnd  = $urandom();
            rd   = rnd[11:7];
            rs2  = (rnd[6:2] == 5'd0) ? 5'd1 : rnd[6:2];
            imm6 = rnd[17:12];
            c    = '0;
            w    = '0;
            expw = '0;
            comp = 1'b1;
            ctrl = 1'b0;
            expd = 1'b0;
            case (cls)
                0:
                begin
                    c    = {C_F3_LI, imm6[5], rd, imm6[4:0], C_Q1};
                    expw = {{6{imm6[5]}}, imm6, 5'd0, 3'b000, rd, OPC_OPIMM};
                    expd = 1'b1;
                end
                1:
                begin
                    c    = {C_F3_ADDI, imm6[5], rd, imm6[4:0], C_Q1};
                    expw = {{6{imm6[5]}}, imm6, rd, 3'b000, rd, OPC_OPIMM};
                    expd = 1'b1;
                end
                2:
                begin
                    c    = {C_F3_JR_MV_ADD, 1'b0, rd, rs2, C_Q2};
                    expw = {7'd0, rs2, 5'd0, 3'b000, rd, OPC_OP};
                    expd = 1'b1;
                end
                3:
                begin
                    c    = {C_F3_JR_MV_ADD, 1'b1, rd, rs2, C_Q2};
                    expw = {7'd0, rs2, rd, 3'b000, rd, OPC_OP};
                    expd = 1'b1;
                end
                4:
                begin
                    c    = {C_F3_J, rnd[28:18], C_Q1};
                    ctrl = 1'b1;
                end
                5:
                begin
                    c    = {C_F3_BEQZ, rnd[28:18], C_Q1};
                    ctrl = 1'b1;
                end
                6:
                    c = {rnd[31:18], C_Q0};
                7:
                begin
                    w    = {rnd[31:7], OPC_OPIMM};
                    comp = 1'b0;
                end
                8:
                begin
                    w    = {rnd[31:7], OPC_OP};
                    comp = 1'b0;
                end
                9:
                begin
                    w    = {rnd[31:7], OPC_JAL};
                    comp = 1'b0;
                    ctrl = 1'b1;
                end
                default:
                begin
                    w    = {rnd[31:7], OPC_BRANCH};
                    comp = 1'b0;
                    ctrl = 1'b1;
                end
            endcase
            exp_tab[n].pc            = RESET_PC + 32'(2 * hw_idx);
            exp_tab[n].is_comp       = comp;
            exp_tab[n].is_ctrl       = ctrl;
            exp_tab[n].is_expandable = expd;
            if (comp)
            begin
                exp_tab[n].raw = {16'h0, c};
                write_half(hw_idx, c);
                hw_idx += 1;
            end
            else
            begin
                exp_tab[n].raw = w;
                if (exp_tab[n].pc[1])
                    cross_count++;
                write_half(hw_idx, w[15:0]);
                write_half(hw_idx + 1, w[31:16]);
                hw_idx += 2;
            end
            exp_tab[n].expanded = expd ? expw : exp_tab[n].raw;
        end
    endtask

    assign fire    = out_valid && out_ready;
    assign exp_rec = (out_count < N_INSTR) ? exp_tab[out_count] : '0;

    // Two long stalls in the run let the queue fill up and stop the APB master
    always @(posedge clk)
    begin
        if (hold_left != 0)
        begin
            out_ready <= 1'b0;
            hold_left <= hold_left - 1;
        end
        else if (fire && out_count % 100 == 50)
        begin
            out_ready <= 1'b0;
            hold_left <= 32;
        end
        else
            out_ready <= $urandom_range(99, 0) < 70;
    end

    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            out_count    <= 0;
            stall_seen   <= 1'b0;
            backoff_seen <= 1'b0;
            exp_paddr    <= {RESET_PC[31:2], 2'b00};
        end
        else
        begin
            if (fire)
                out_count <= out_count + 1;
            if (out_valid && !out_ready)
                stall_seen <= 1'b1;
            // Once the first read is done the master only goes idle on a full queue
            if (!apb_req.psel && exp_paddr != {RESET_PC[31:2], 2'b00})
                backoff_seen <= 1'b1;
            if (apb_req.penable && apb_rsp.pready)
                exp_paddr <= exp_paddr + 32'd4;
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES)
            fail_with($sformatf("timeout after %0d cycles with %0d of %0d instructions delivered",
                                cycles, out_count, N_INSTR));
    end

    a_pc: assert property (@(posedge clk) disable iff (!arst_n)
        fire && out_count < N_INSTR |-> dut_out.pc == exp_rec.pc)
        else report_mismatch("o_out.pc", $sampled(exp_rec.pc), $sampled(dut_out.pc));

    a_raw: assert property (@(posedge clk) disable iff (!arst_n)
        fire && out_count < N_INSTR |-> dut_out.raw == exp_rec.raw)
        else report_mismatch("o_out.raw", $sampled(exp_rec.raw), $sampled(dut_out.raw));

    a_expanded: assert property (@(posedge clk) disable iff (!arst_n)
        fire && out_count < N_INSTR |-> dut_out.expanded == exp_rec.expanded)
        else report_mismatch("o_out.expanded", $sampled(exp_rec.expanded),
                             $sampled(dut_out.expanded));

    // Flags in the order is_comp, is_ctrl, is_expandable
    a_flags: assert property (@(posedge clk) disable iff (!arst_n)
        fire && out_count < N_INSTR |-> dut_out[2:0] == exp_rec[2:0])
        else report_mismatch("o_out flags", 32'($sampled(exp_rec[2:0])),
                             32'($sampled(dut_out[2:0])));

    a_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(dut_out))
        else fail_with("o_out or o_out_valid changed while i_out_ready was low");

    a_read_only: assert property (@(posedge clk) disable iff (!arst_n)
        apb_req.psel |-> !apb_req.pwrite)
        else fail_with("pwrite was high during an instruction fetch");

    a_setup_first: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(apb_req.penable) |-> apb_req.psel && $past(apb_req.psel && !apb_req.penable))
        else fail_with("penable rose without a setup cycle before it");

    a_paddr_hold: assert property (@(posedge clk) disable iff (!arst_n)
        apb_req.psel && !(apb_req.penable && apb_rsp.pready) |=> $stable(apb_req.paddr))
        else fail_with("paddr changed before the memory raised pready");

    a_paddr_order: assert property (@(posedge clk) disable iff (!arst_n)
        apb_req.penable && apb_rsp.pready |-> apb_req.paddr == exp_paddr)
        else report_mismatch("paddr", $sampled(exp_paddr), $sampled(apb_req.paddr));

    initial
    begin
        void'($urandom(32'hc8e));
        build_program();
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        wait (out_count == N_INSTR);
        // Let the checks of the last transfer finish
        @(negedge clk);
        if (cross_count == 0)
            fail_with("the program has no 32-bit instruction across a word boundary");
        else if (!stall_seen)
            fail_with("decode never held back a valid instruction");
        else if (!backoff_seen)
            fail_with("the queue never filled far enough to stop the APB master");
        else
        begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

//--- src.f
hw/rv_isa_pkg.sv
hw/fetch_pkg.sv
hw/fetch_apb_master.sv
hw/rv_fetch_buf.sv
hw/rvc_expand.sv
hw/rv_predecode.sv
hw/fetch_out_stage.sv
hw/rv_fetch_top.sv
tb/tb_apb_imem.sv
tb/tb_fetch_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
